//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= uart_link_tb
FILELIST  ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/uart_link_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_link_macros.svh"

module uart_link_tb;

   localparam int P       = `UART_CLKS_PER_BIT;
   localparam int N_CMDS  = 20;
   localparam int N_INJ   = 9;
   // 40 commands of two frames, doubled for handshakes and injected frames.
   localparam int TIMEOUT_CYCLES = 2 * (40 * 2 * `UART_FRAME_BITS * P) + 2000;

   logic        clk;
   logic        rst_n;
   logic        cmd_req;
   logic [15:0] cmd_data;
   logic        cmd_ack;
   logic        tx;
   logic        rx_line;
   logic        rd_req;
   logic [7:0]  rd_data;
   logic        rd_parity_err;
   logic        rd_ack;
   logic        rx_overrun;
   logic        bb_rx;
   logic        loop_sel;

   logic [31:0] lfsr = 32'hbdc6_ce46;
   logic [7:0]  tx_exp [$];
   logic [8:0]  rx_exp [$];
   int          frames_done = 0;
   int          errors = 0;
   int          err_mark = 0;
   int          tests_done = 0;

   // loopback takes the DUT's own tx, otherwise the bit-banged line.
   assign rx_line = loop_sel ? tx : bb_rx;

   uart_link_top uart_link_top_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .cmd_req       (cmd_req),
      .cmd_data      (cmd_data),
      .cmd_ack       (cmd_ack),
      .tx            (tx),
      .rx            (rx_line),
      .rd_req        (rd_req),
      .rd_data       (rd_data),
      .rd_parity_err (rd_parity_err),
      .rd_ack        (rd_ack),
      .rx_overrun    (rx_overrun)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // model and stimulus helpers.
   ////////////////////////////////////////////////////////////////////////////

   // taps 32, 22, 2, 1.
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic logic odd_parity(input logic [7:0] d);
      int ones;
      ones = 0;
      for (int i = 0; i < 8; i++) begin
         ones = ones + int'(d[i]);
      end
      return (ones % 2 == 0) ? 1'b1 : 1'b0;
   endfunction

   // bit 10 goes out first.
   function automatic logic [10:0] build_frame(input logic [7:0] d);
      return {1'b0, d, odd_parity(d), 1'b1};
   endfunction

   task automatic send_cmd(input logic [15:0] word, output int frames_at_ack);
      tx_exp.push_back(word[15:8]);
      tx_exp.push_back(word[7:0]);
      @(posedge clk);
      #1;
      cmd_data = word;
      cmd_req  = 1'b1;
      do @(negedge clk); while (!cmd_ack);
      frames_at_ack = frames_done;
      @(posedge clk);
      #1;
      cmd_req = 1'b0;
      do @(negedge clk); while (cmd_ack);
   endtask

   // every cycle of each bit is sampled, the bit middle included.
   task automatic capture_frame();
      logic [7:0]  exp_byte;
      logic [10:0] exp_bits;
      logic        bad;
      do @(negedge clk); while (tx !== 1'b0);
      if (tx_exp.size() == 0) begin
         $display("a frame was seen on tx but no byte was queued for it");
         errors++;
         return;
      end
      exp_byte = tx_exp.pop_front();
      exp_bits = build_frame(exp_byte);
      bad      = 1'b0;
      for (int b = 0; b < `UART_FRAME_BITS; b++) begin
         for (int c = 0; c < P; c++) begin
            if (b != 0 || c != 0) begin
               @(negedge clk);
            end
            if (!bad && tx !== exp_bits[10-b]) begin
               $display("ERR %0t tx expected %b got %b (frame bit %0d of byte %h)",
                        $time, exp_bits[10-b], tx, b, exp_byte);
               errors++;
               bad = 1'b1;
            end
         end
      end
      frames_done++;
   endtask

   task automatic send_frame(input logic [10:0] bits);
      for (int b = 10; b >= 0; b--) begin
         @(posedge clk);
         #1;
         bb_rx = bits[b];
         repeat (P - 1) @(posedge clk);
      end
      @(posedge clk);
      #1;
      bb_rx = 1'b1;
      repeat (2 * P) @(posedge clk);
   endtask

   task automatic read_byte();
      logic [8:0]  entry;
      logic [31:0] dly;
      if (rx_exp.size() == 0) begin
         $display("a read was started with no received byte expected");
         errors++;
         return;
      end
      entry = rx_exp.pop_front();
      do @(negedge clk); while (!rd_req);
      if (rd_data !== entry[7:0]) begin
         $display("ERR %0t rd_data expected %h got %h", $time, entry[7:0], rd_data);
         errors++;
      end
      if (rd_parity_err !== entry[8]) begin
         $display("ERR %0t rd_parity_err expected %b got %b", $time, entry[8],
                  rd_parity_err);
         errors++;
      end
      dly = take_bits(3);
      repeat (dly) @(posedge clk);
      @(posedge clk);
      #1;
      rd_ack = 1'b1;
      do @(negedge clk); while (rd_req);
      @(posedge clk);
      #1;
      rd_ack = 1'b0;
   endtask

   task automatic log_test_result(input int num, input string name);
      $display("test %0d %s finished with %0d errors", num, name, errors - err_mark);
      err_mark = errors;
      tests_done++;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // test sequence.
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      logic [31:0] r;
      logic [15:0] word_a;
      logic [15:0] word_b;
      logic [7:0]  d;
      logic [10:0] bits;
      int          base;
      int          ack_a;
      int          ack_b;
      cmd_req  = 1'b0;
      cmd_data = '0;
      rd_ack   = 1'b0;
      bb_rx    = 1'b1;
      loop_sel = 1'b0;
      rst_n    = 1'b0;
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;

      @(negedge clk);
      if (tx !== 1'b1) begin
         $display("ERR %0t tx expected 1 got %b", $time, tx);
         errors++;
      end
      if (cmd_ack !== 1'b0) begin
         $display("ERR %0t cmd_ack expected 0 got %b", $time, cmd_ack);
         errors++;
      end
      if (rd_req !== 1'b0) begin
         $display("ERR %0t rd_req expected 0 got %b", $time, rd_req);
         errors++;
      end
      if (rx_overrun !== 1'b0) begin
         $display("ERR %0t rx_overrun expected 0 got %b", $time, rx_overrun);
         errors++;
      end
      log_test_result(1, "reset values");

      for (int i = 0; i < N_CMDS; i++) begin
         r = take_bits(16);
         word_a = r[15:0];
         fork
            send_cmd(word_a, ack_a);
            begin
               capture_frame();
               capture_frame();
            end
         join
      end
      log_test_result(2, "transmit format");

      @(posedge clk);
      #1;
      loop_sel = 1'b1;
      for (int i = 0; i < N_CMDS; i++) begin
         r = take_bits(16);
         word_a = r[15:0];
         rx_exp.push_back({1'b0, word_a[15:8]});
         rx_exp.push_back({1'b0, word_a[7:0]});
         fork
            send_cmd(word_a, ack_a);
            begin
               capture_frame();
               capture_frame();
            end
            begin
               read_byte();
               read_byte();
            end
         join
      end
      @(posedge clk);
      #1;
      loop_sel = 1'b0;
      log_test_result(3, "loopback");

      // cycle through flipped parity, low stop bit and a clean frame.
      for (int i = 0; i < N_INJ; i++) begin
         r = take_bits(8);
         d = r[7:0];
         bits = build_frame(d);
         if (i % 3 == 0) begin
            bits[1] = ~bits[1];
         end else if (i % 3 == 1) begin
            bits[0] = 1'b0;
         end
         send_frame(bits);
         if (i % 3 == 1) begin
            @(negedge clk);
            if (rd_req !== 1'b0) begin
               $display("ERR %0t rd_req expected 0 got %b", $time, rd_req);
               errors++;
            end
         end else begin
            rx_exp.push_back({(i % 3 == 0), d});
            read_byte();
         end
      end
      log_test_result(4, "injected errors");

      @(negedge clk);
      if (rx_overrun !== 1'b0) begin
         $display("ERR %0t rx_overrun expected 0 got %b", $time, rx_overrun);
         errors++;
      end
      for (int i = 0; i <= `UART_RX_FIFO_DEPTH; i++) begin
         r = take_bits(8);
         d = r[7:0];
         if (i < `UART_RX_FIFO_DEPTH) begin
            rx_exp.push_back({1'b0, d});
         end
         send_frame(build_frame(d));
      end
      @(negedge clk);
      if (rx_overrun !== 1'b1) begin
         $display("ERR %0t rx_overrun expected 1 got %b", $time, rx_overrun);
         errors++;
      end
      repeat (`UART_RX_FIFO_DEPTH) read_byte();
      repeat (2 * P) @(negedge clk);
      if (rd_req !== 1'b0) begin
         $display("a byte beyond the buffer depth was offered on rd_req");
         errors++;
      end
      log_test_result(5, "overrun");

      // second request goes up as soon as the first handshake is released.
      base = frames_done;
      r = take_bits(16);
      word_a = r[15:0];
      r = take_bits(16);
      word_b = r[15:0];
      fork
         begin
            send_cmd(word_a, ack_a);
            send_cmd(word_b, ack_b);
         end
         repeat (4) capture_frame();
      join
      if (ack_a != base) begin
         $display("cmd_ack for the first command came after its frames had started");
         errors++;
      end
      if (ack_b - base < 2) begin
         $display("cmd_ack for the second command rose before the first command's frames ended");
         errors++;
      end
      log_test_result(6, "back-pressure");

      $display("%0d tests run, %0d errors", tests_done, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("timeout after %0d cycles, a handshake or frame never completed",
               TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
+incdir+hdl
hdl/uart_link_pkg.sv
hdl/cmd_intake.sv
hdl/uart_tx_serializer.sv
hdl/uart_rx_deserializer.sv
hdl/rx_byte_out.sv
hdl/uart_link_top.sv
dv/uart_link_tb.sv

//--- hdl/cmd_intake.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_intake
   import uart_link_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        rst_n,
   input  wire logic        cmd_req,
   input  wire logic [15:0] cmd_data,
   output logic             cmd_ack,
   output logic             tx_byte_req,
   output logic [7:0]       tx_byte,
   input  wire logic        tx_byte_ack
);

   intake_state_t state;
   logic [15:0]   cmd_word;
   logic          hs_done;

   // high byte first, low byte once the first handshake is through.
   assign tx_byte = (state == IN_SEND_LO) ? cmd_word[7:0] : cmd_word[15:8];

   always_ff @(posedge clk) begin
      if (state == IN_IDLE && cmd_req) begin
         cmd_word <= cmd_data;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= IN_IDLE;
         cmd_ack     <= 1'b0;
         tx_byte_req <= 1'b0;
         hs_done     <= 1'b0;
      end else begin
         case (state)
            IN_IDLE: begin
               if (cmd_req) begin
                  state <= IN_ACK;
               end
            end
            IN_ACK: begin
               cmd_ack <= 1'b1;
               state   <= IN_SEND_HI;
            end
            IN_SEND_HI, IN_SEND_LO: begin
               if (!hs_done) begin
                  if (tx_byte_ack) begin
                     tx_byte_req <= 1'b0;
                     hs_done     <= 1'b1;
                  end else begin
                     tx_byte_req <= 1'b1;
                  end
               end else if (!tx_byte_ack) begin
                  // serializer has released, the frame is over.
                  hs_done <= 1'b0;
                  if (state == IN_SEND_HI) begin
                     state       <= IN_SEND_LO;
                     tx_byte_req <= 1'b1;
                  end else begin
                     state <= IN_WAIT_REL;
                  end
               end
            end
            IN_WAIT_REL: begin
               if (!cmd_req && !tx_byte_ack) begin
                  cmd_ack <= 1'b0;
                  state   <= IN_IDLE;
               end
            end
            default: state <= IN_IDLE;
         endcase
      end
   end

   a_cmd_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (cmd_req && !cmd_ack && $past(cmd_req && !cmd_ack)) |-> $stable(cmd_data))
      else $error("cmd_data changed while cmd_req was waiting for cmd_ack");

endmodule

`default_nettype wire

//--- hdl/rx_byte_out.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_link_macros.svh"

module rx_byte_out (
   input  wire logic       clk,
   input  wire logic       rst_n,
   input  wire logic       rx_byte_valid,
   input  wire logic [7:0] rx_byte,
   input  wire logic       rx_parity_err,
   output logic            rd_req,
   output logic [7:0]      rd_data,
   output logic            rd_parity_err,
   input  wire logic       rd_ack,
   output logic            rx_overrun
);

   localparam int DEPTH = `UART_RX_FIFO_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);
   localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
   localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

   logic [7:0]       mem_data [DEPTH];
   logic             mem_err  [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;

   assign push          = rx_byte_valid && (count != CNT_FULL);
   assign pop           = rd_req && rd_ack;
   assign rd_data       = mem_data[rd_ptr];
   assign rd_parity_err = mem_err[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         mem_data[wr_ptr] <= rx_byte;
         mem_err[wr_ptr]  <= rx_parity_err;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         rd_req     <= 1'b0;
         rx_overrun <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + CNT_W'(push) - CNT_W'(pop);
         // offer the head only once the previous ack has gone.
         if (pop) begin
            rd_req <= 1'b0;
         end else if (!rd_req && !rd_ack && count != '0) begin
            rd_req <= 1'b1;
         end
         if (rx_byte_valid && !push) begin
            rx_overrun <= 1'b1;
         end
      end
   end

   a_rd_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (rd_req && $past(rd_req)) |-> $stable(rd_data))
      else $error("rd_data changed while rd_req was high");

endmodule

`default_nettype wire

//--- hdl/uart_link_macros.svh
`ifndef UART_LINK_MACROS_SVH
`define UART_LINK_MACROS_SVH

// clocks per bit period, even and at least 4.
`define UART_CLKS_PER_BIT 4

// start, eight data bits, parity and stop.
`define UART_FRAME_BITS 11

// entries of the receive buffer.
`define UART_RX_FIFO_DEPTH 2

`endif

//--- hdl/uart_link_pkg.sv
`default_nettype none

package uart_link_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // command intake.
   ////////////////////////////////////////////////////////////////////////////
   typedef enum logic [2:0] {
      IN_IDLE,
      IN_ACK,
      IN_SEND_HI,
      IN_SEND_LO,
      IN_WAIT_REL
   } intake_state_t;

   // serializer is either idle or busy with a frame.
   typedef enum logic {
      TX_IDLE,
      TX_SHIFT
   } tx_state_t;

   // deserializer phases of one frame.
   typedef enum logic [2:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_PARITY,
      RX_STOP
   } rx_state_t;

endpackage

`default_nettype wire

//--- hdl/uart_link_top.sv
`timescale 1ns/1ns
`default_nettype none

module uart_link_top (
   input  wire logic        clk,
   input  wire logic        rst_n,
   input  wire logic        cmd_req,
   input  wire logic [15:0] cmd_data,
   output logic             cmd_ack,
   output logic             tx,
   input  wire logic        rx,
   output logic             rd_req,
   output logic [7:0]       rd_data,
   output logic             rd_parity_err,
   input  wire logic        rd_ack,
   output logic             rx_overrun
);

   logic       tx_byte_req;
   logic [7:0] tx_byte;
   logic       tx_byte_ack;
   logic       rx_byte_valid;
   logic [7:0] rx_byte;
   logic       rx_parity_err;

   ////////////////////////////////////////////////////////////////////////////
   // transmit side.
   ////////////////////////////////////////////////////////////////////////////
   cmd_intake cmd_intake_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .cmd_req     (cmd_req),
      .cmd_data    (cmd_data),
      .cmd_ack     (cmd_ack),
      .tx_byte_req (tx_byte_req),
      .tx_byte     (tx_byte),
      .tx_byte_ack (tx_byte_ack)
   );

   uart_tx_serializer uart_tx_serializer_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .tx_byte_req (tx_byte_req),
      .tx_byte     (tx_byte),
      .tx_byte_ack (tx_byte_ack),
      .tx          (tx)
   );

   ////////////////////////////////////////////////////////////////////////////
   // receive side.
   ////////////////////////////////////////////////////////////////////////////
   uart_rx_deserializer uart_rx_deserializer_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .rx            (rx),
      .rx_byte_valid (rx_byte_valid),
      .rx_byte       (rx_byte),
      .rx_parity_err (rx_parity_err)
   );

   rx_byte_out rx_byte_out_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .rx_byte_valid (rx_byte_valid),
      .rx_byte       (rx_byte),
      .rx_parity_err (rx_parity_err),
      .rd_req        (rd_req),
      .rd_data       (rd_data),
      .rd_parity_err (rd_parity_err),
      .rd_ack        (rd_ack),
      .rx_overrun    (rx_overrun)
   );

endmodule

`default_nettype wire

//--- hdl/uart_rx_deserializer.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_link_macros.svh"

module uart_rx_deserializer
   import uart_link_pkg::*;
(
   input  wire logic clk,
   input  wire logic rst_n,
   input  wire logic rx,
   output logic      rx_byte_valid,
   output logic [7:0] rx_byte,
   output logic      rx_parity_err
);

   localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`UART_CLKS_PER_BIT - 1);
   localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(`UART_CLKS_PER_BIT / 2 - 1);

   rx_state_t        state;
   logic             rx_s1;
   logic             rx_s2;
   logic             rx_d;
   logic [CNT_W-1:0] clk_cnt;
   logic [2:0]       bit_cnt;
   logic [7:0]       data_sh;
   logic             par_bit;
   logic             fall;
   logic             tick;

   assign fall = rx_d & ~rx_s2;
   assign tick = (clk_cnt == CNT_LAST);

   // two stage synchronizer, plus one more stage for edge detection.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_s1 <= 1'b1;
         rx_s2 <= 1'b1;
         rx_d  <= 1'b1;
      end else begin
         rx_s1 <= rx;
         rx_s2 <= rx_s1;
         rx_d  <= rx_s2;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // frame sequencing.
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state         <= RX_IDLE;
         clk_cnt       <= '0;
         bit_cnt       <= '0;
         rx_byte_valid <= 1'b0;
      end else begin
         rx_byte_valid <= 1'b0;
         case (state)
            RX_IDLE: begin
               clk_cnt <= '0;
               if (fall) begin
                  state <= RX_START;
               end
            end
            RX_START: begin
               if (clk_cnt == CNT_HALF) begin
                  // a glitch shorter than half a bit is ignored.
                  clk_cnt <= '0;
                  bit_cnt <= '0;
                  state   <= rx_s2 ? RX_IDLE : RX_DATA;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            RX_DATA, RX_PARITY, RX_STOP: begin
               if (tick) begin
                  clk_cnt <= '0;
                  if (state == RX_DATA) begin
                     bit_cnt <= bit_cnt + 1'b1;
                     if (bit_cnt == 3'd7) begin
                        state <= RX_PARITY;
                     end
                  end else if (state == RX_PARITY) begin
                     state <= RX_STOP;
                  end else begin
                     // low stop bit means a framing error, byte is lost.
                     rx_byte_valid <= rx_s2;
                     state         <= RX_IDLE;
                  end
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (tick) begin
         if (state == RX_DATA) begin
            data_sh <= {data_sh[6:0], rx_s2};
         end else if (state == RX_PARITY) begin
            par_bit <= rx_s2;
         end else if (state == RX_STOP) begin
            rx_byte       <= data_sh;
            rx_parity_err <= ~^{data_sh, par_bit};
         end
      end
   end

   a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
      rx_byte_valid |=> !rx_byte_valid)
      else $error("rx_byte_valid held for more than one cycle");

endmodule

`default_nettype wire

//--- hdl/uart_tx_serializer.sv
`timescale 1ns/1ns
`default_nettype none

`include "uart_link_macros.svh"

module uart_tx_serializer
   import uart_link_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       rst_n,
   input  wire logic       tx_byte_req,
   input  wire logic [7:0] tx_byte,
   output logic            tx_byte_ack,
   output logic            tx
);

   localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
   localparam int BIT_W = $clog2(`UART_FRAME_BITS);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`UART_CLKS_PER_BIT - 1);
   localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`UART_FRAME_BITS - 1);

   tx_state_t                   state;
   logic [`UART_FRAME_BITS-1:0] shreg;
   logic [CNT_W-1:0]            clk_cnt;
   logic [BIT_W-1:0]            bit_cnt;
   logic                        start;
   logic                        bit_end;
   logic                        frame_end;
   logic                        ack_drop;

   assign start     = (state == TX_IDLE) && tx_byte_req && !tx_byte_ack;
   assign bit_end   = (clk_cnt == CNT_LAST);
   assign frame_end = (state == TX_SHIFT) && bit_end && (bit_cnt == BIT_LAST);

   // ack is held until the frame is out, which stalls the next byte.
   assign ack_drop  = tx_byte_ack && !tx_byte_req && ((state == TX_IDLE) || frame_end);

   ////////////////////////////////////////////////////////////////////////////
   // frame register, msb goes out first.
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (start) begin
         // odd parity over the data byte.
         shreg <= {1'b0, tx_byte, ~^tx_byte, 1'b1};
      end else if (state == TX_SHIFT && bit_end) begin
         shreg <= {shreg[`UART_FRAME_BITS-2:0], 1'b1};
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state       <= TX_IDLE;
         tx_byte_ack <= 1'b0;
         tx          <= 1'b1;
         clk_cnt     <= '0;
         bit_cnt     <= '0;
      end else begin
         if (start) begin
            state       <= TX_SHIFT;
            tx_byte_ack <= 1'b1;
            tx          <= 1'b0;
            clk_cnt     <= '0;
            bit_cnt     <= '0;
         end else if (state == TX_SHIFT) begin
            if (bit_end) begin
               clk_cnt <= '0;
               if (frame_end) begin
                  state <= TX_IDLE;
                  tx    <= 1'b1;
               end else begin
                  bit_cnt <= bit_cnt + 1'b1;
                  tx      <= shreg[`UART_FRAME_BITS-2];
               end
            end else begin
               clk_cnt <= clk_cnt + 1'b1;
            end
         end
         if (ack_drop) begin
            tx_byte_ack <= 1'b0;
         end
      end
   end

   a_tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
      (state == TX_IDLE) |-> tx)
      else $error("tx low while the serializer is idle");

endmodule

`default_nettype wire
